// ==== verilog/pulse_cfg_pkg.sv ====
package pulse_cfg_pkg;

	// Both limits and the cycle counter share this width.
	localparam int CFG_LIMIT_WIDTH = 16;

	// One hex digit per nibble, edited one at a time.
	localparam int CFG_NIBBLES = 4;

	localparam int CFG_INDEX_WIDTH = 2;  // Selects one of CFG_NIBBLES nibbles.

	// High phase of 256 cycles after reset.
	localparam logic [CFG_LIMIT_WIDTH-1:0] CFG_HIGH_RESET = 16'h00FF;

	// Low phase of 2048 cycles after reset.
	localparam logic [CFG_LIMIT_WIDTH-1:0] CFG_LOW_RESET = 16'h07FF;

endpackage

// ==== verilog/board_io_pkg.sv ====
package board_io_pkg;

	// Bit 0 drives segment a, bit 6 drives segment g.
	localparam int IO_SEGMENTS = 7;

	// The board lights a segment when its line is low.
	localparam bit IO_SEG_ACTIVE_LOW = 1'b1;

	localparam int IO_DEBOUNCE_CYCLES = 250000;  // 10 ms at 25 MHz.

endpackage

// ==== verilog/button_debouncer.sv ====
`timescale 1ns/1ps

module button_debouncer #(
	parameter int P_DEBOUNCE_CYCLES = board_io_pkg::IO_DEBOUNCE_CYCLES
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_button,
	output logic o_level,
	output logic o_press
);

	localparam int LP_COUNT_WIDTH = $clog2(P_DEBOUNCE_CYCLES + 1);
	localparam logic [LP_COUNT_WIDTH-1:0] LP_COUNT_LAST = LP_COUNT_WIDTH'(P_DEBOUNCE_CYCLES - 1);

	logic [1:0]                sync_ff;
	logic [LP_COUNT_WIDTH-1:0] stable_count;
	logic                      level;
	logic                      accept;

	// The new value has now been seen on P_DEBOUNCE_CYCLES cycles in a row.
	assign accept = (sync_ff[1] != level) && (stable_count == LP_COUNT_LAST);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync_ff      <= '0;
			stable_count <= '0;
			level        <= 1'b0;
			o_press      <= 1'b0;
		end else begin
			sync_ff <= {sync_ff[0], i_button};
			o_press <= accept && sync_ff[1];  // High together with the first cycle of the new level.
			if (accept) begin
				level        <= sync_ff[1];
				stable_count <= '0;
			end else if (sync_ff[1] != level) begin
				stable_count <= stable_count + 1'b1;
			end else begin
				stable_count <= '0;  // A bounce back restarts the count.
			end
		end
	end

	assign o_level = level;

endmodule

// ==== verilog/limit_editor.sv ====
`timescale 1ns/1ps

module limit_editor (
	input  logic                                       i_clk,
	input  logic                                       i_arst_n,
	input  logic                                       i_up,
	input  logic                                       i_down,
	input  logic                                       i_select,
	input  logic                                       i_edit,
	output logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0]  o_high_limit,
	output logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0]  o_low_limit,
	output logic                                       o_sel_high,
	output logic                                       o_edit_mode,
	output logic [pulse_cfg_pkg::CFG_INDEX_WIDTH-1:0]  o_index,
	output logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH/pulse_cfg_pkg::CFG_NIBBLES-1:0] o_nibble
);

	localparam int LP_WIDTH        = pulse_cfg_pkg::CFG_LIMIT_WIDTH;
	localparam int LP_INDEX_WIDTH  = pulse_cfg_pkg::CFG_INDEX_WIDTH;
	localparam int LP_NIBBLE_WIDTH = LP_WIDTH / pulse_cfg_pkg::CFG_NIBBLES;

	logic [LP_WIDTH-1:0]        high_limit;
	logic [LP_WIDTH-1:0]        low_limit;
	logic [LP_INDEX_WIDTH-1:0]  high_index;
	logic [LP_INDEX_WIDTH-1:0]  low_index;
	logic                       sel_high;
	logic                       edit_mode;

	logic [LP_WIDTH-1:0]        active_limit;
	logic [LP_INDEX_WIDTH-1:0]  active_index;
	logic [LP_NIBBLE_WIDTH-1:0] active_nibble;
	logic [LP_WIDTH-1:0]        limit_next;
	logic [LP_INDEX_WIDTH-1:0]  index_next;

	assign active_limit  = sel_high ? high_limit : low_limit;
	assign active_index  = sel_high ? high_index : low_index;
	assign active_nibble = active_limit[active_index * LP_NIBBLE_WIDTH +: LP_NIBBLE_WIDTH];

	// Up wins over down, and both wrap within their own field.
	always_comb begin
		limit_next = active_limit;
		if (i_up) begin
			index_next = active_index + 1'b1;
			limit_next[active_index * LP_NIBBLE_WIDTH +: LP_NIBBLE_WIDTH] = active_nibble + 1'b1;
		end else begin
			index_next = active_index - 1'b1;
			limit_next[active_index * LP_NIBBLE_WIDTH +: LP_NIBBLE_WIDTH] = active_nibble - 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			high_limit <= pulse_cfg_pkg::CFG_HIGH_RESET;
			low_limit  <= pulse_cfg_pkg::CFG_LOW_RESET;
			high_index <= '0;
			low_index  <= '0;
			sel_high   <= 1'b0;
			edit_mode  <= 1'b0;
		end else if (i_up || i_down) begin
			if (edit_mode) begin
				if (sel_high) begin
					high_limit <= limit_next;
				end else begin
					low_limit <= limit_next;
				end
			end else if (sel_high) begin
				high_index <= index_next;
			end else begin
				low_index <= index_next;
			end
		end else if (i_select) begin
			sel_high <= ~sel_high;
		end else if (i_edit) begin
			edit_mode <= ~edit_mode;
		end
	end

	assign o_high_limit = high_limit;
	assign o_low_limit  = low_limit;
	assign o_sel_high   = sel_high;
	assign o_edit_mode  = edit_mode;
	assign o_index      = active_index;
	assign o_nibble     = active_nibble;

endmodule

// ==== verilog/pulse_generator.sv ====
`timescale 1ns/1ps

module pulse_generator (
	input  logic                                      i_clk,
	input  logic                                      i_arst_n,
	input  logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] i_high_limit,
	input  logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] i_low_limit,
	output logic                                      o_pulse
);

	logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] cycle_count;
	logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] phase_limit;
	logic                                      pulse;
	logic                                      phase_end;

	assign phase_limit = pulse ? i_high_limit : i_low_limit;

	// At or above, so a limit lowered mid-phase ends the phase at once.
	assign phase_end = (cycle_count >= phase_limit);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cycle_count <= '0;
			pulse       <= 1'b0;  // Start in the low phase.
		end else if (phase_end) begin
			cycle_count <= '0;
			pulse       <= ~pulse;
		end else begin
			cycle_count <= cycle_count + 1'b1;
		end
	end

	assign o_pulse = pulse;

endmodule

// ==== verilog/hex_to_segments.sv ====
`timescale 1ns/1ps

module hex_to_segments (
	input  logic                                i_clk,
	input  logic                                i_arst_n,
	input  logic [3:0]                          i_value,
	output logic [board_io_pkg::IO_SEGMENTS-1:0] o_segments
);

	localparam logic [board_io_pkg::IO_SEGMENTS-1:0] LP_POLARITY =
		{board_io_pkg::IO_SEGMENTS{board_io_pkg::IO_SEG_ACTIVE_LOW}};

	logic [board_io_pkg::IO_SEGMENTS-1:0] glyph;

	always_comb begin
		case (i_value)  // Set bits light segments g down to a.
			4'h0: glyph = 7'h3F;
			4'h1: glyph = 7'h06;
			4'h2: glyph = 7'h5B;
			4'h3: glyph = 7'h4F;
			4'h4: glyph = 7'h66;
			4'h5: glyph = 7'h6D;
			4'h6: glyph = 7'h7D;
			4'h7: glyph = 7'h07;
			4'h8: glyph = 7'h7F;
			4'h9: glyph = 7'h6F;
			4'hA: glyph = 7'h77;
			4'hB: glyph = 7'h7C;
			4'hC: glyph = 7'h39;
			4'hD: glyph = 7'h5E;
			4'hE: glyph = 7'h79;
			default: glyph = 7'h71;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_segments <= 7'h3F ^ LP_POLARITY;  // Shows 0.
		end else begin
			o_segments <= glyph ^ LP_POLARITY;
		end
	end

endmodule

// ==== verilog/pulse_tuner_top.sv ====
`timescale 1ns/1ps

module pulse_tuner_top #(
	parameter int P_DEBOUNCE_CYCLES = board_io_pkg::IO_DEBOUNCE_CYCLES
) (
	input  logic                                 i_clk,
	input  logic                                 i_arst_n,
	input  logic                                 i_btn_up,
	input  logic                                 i_btn_down,
	input  logic                                 i_btn_select,
	input  logic                                 i_btn_edit,
	output logic [board_io_pkg::IO_SEGMENTS-1:0] o_seg_index,
	output logic [board_io_pkg::IO_SEGMENTS-1:0] o_seg_value,
	output logic                                 o_led_sel_high,
	output logic                                 o_led_edit,
	output logic                                 o_pulse
);

	logic                                      press_up;
	logic                                      press_down;
	logic                                      press_select;
	logic                                      press_edit;
	logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] high_limit;
	logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] low_limit;
	logic [pulse_cfg_pkg::CFG_INDEX_WIDTH-1:0] index;
	logic [3:0]                                nibble;

	// The editor takes only the press strobes.
	button_debouncer #(.P_DEBOUNCE_CYCLES(P_DEBOUNCE_CYCLES)) debounce_up_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_button(i_btn_up),
		.o_level(), .o_press(press_up)
	);
	button_debouncer #(.P_DEBOUNCE_CYCLES(P_DEBOUNCE_CYCLES)) debounce_down_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_button(i_btn_down),
		.o_level(), .o_press(press_down)
	);
	button_debouncer #(.P_DEBOUNCE_CYCLES(P_DEBOUNCE_CYCLES)) debounce_select_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_button(i_btn_select),
		.o_level(), .o_press(press_select)
	);
	button_debouncer #(.P_DEBOUNCE_CYCLES(P_DEBOUNCE_CYCLES)) debounce_edit_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_button(i_btn_edit),
		.o_level(), .o_press(press_edit)
	);

	limit_editor limit_editor_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_up(press_up), .i_down(press_down), .i_select(press_select), .i_edit(press_edit),
		.o_high_limit(high_limit), .o_low_limit(low_limit),
		.o_sel_high(o_led_sel_high), .o_edit_mode(o_led_edit),
		.o_index(index), .o_nibble(nibble)
	);

	pulse_generator pulse_generator_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_high_limit(high_limit), .i_low_limit(low_limit), .o_pulse(o_pulse)
	);

	hex_to_segments index_display_i (  // Left digit.
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_value({2'b00, index}), .o_segments(o_seg_index)
	);
	hex_to_segments value_display_i (  // Right digit.
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_value(nibble), .o_segments(o_seg_value)
	);

endmodule

// ==== verif/pulse_tuner_tb.sv ====
`timescale 1ns/1ps

module pulse_tuner_tb;

	localparam int LP_CYCLE_LIMIT = 40000;
	localparam int BTN_UP     = 0;
	localparam int BTN_DOWN   = 1;
	localparam int BTN_SELECT = 2;
	localparam int BTN_EDIT   = 3;

	logic       i_clk;
	logic       i_arst_n;
	logic       i_btn_up;
	logic       i_btn_down;
	logic       i_btn_select;
	logic       i_btn_edit;
	logic [6:0] o_seg_index;
	logic [6:0] o_seg_value;
	logic       o_led_sel_high;
	logic       o_led_edit;
	logic       o_pulse;

	// In the model, limit 0 is the low limit and limit 1 the high limit.
	logic [pulse_cfg_pkg::CFG_LIMIT_WIDTH-1:0] model_limit [2];
	logic [1:0] model_idx [2];
	bit         model_sel;
	bit         model_edit;
	bit         bounce_active;

	integer seed;
	int     mismatch_count;
	int     failure_count;
	int     cycle_count = 0;

	pulse_tuner_top #(.P_DEBOUNCE_CYCLES(4)) pulse_tuner_top_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_btn_up(i_btn_up), .i_btn_down(i_btn_down),
		.i_btn_select(i_btn_select), .i_btn_edit(i_btn_edit),
		.o_seg_index(o_seg_index), .o_seg_value(o_seg_value),
		.o_led_sel_high(o_led_sel_high), .o_led_edit(o_led_edit), .o_pulse(o_pulse)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= LP_CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles before the tests were done", cycle_count);
			$display("Test failures found");
			$finish;
		end
	end

	// A pulse shorter than the debounce length leaves every display output as it was.
	display_steady: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		bounce_active |-> $stable({o_seg_index, o_seg_value, o_led_sel_high, o_led_edit}))
		else begin
			mismatch_count++;
			$display("Mismatch at %0t: display changed during a bounce", $time);
		end

	// The board drives these glyphs active low, and bit 0 is segment a.
	function automatic logic [6:0] expected_glyph(input logic [3:0] value);
		case (value)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	function automatic logic [3:0] model_nibble();
		return model_limit[model_sel][model_idx[model_sel]*4 +: 4];
	endfunction

	function automatic string button_name(input int btn);
		case (btn)
			BTN_UP:     return "up";
			BTN_DOWN:   return "down";
			BTN_SELECT: return "select";
			default:    return "edit";
		endcase
	endfunction

	function automatic bit display_matches();
		return o_seg_index === expected_glyph({2'b00, model_idx[model_sel]})
			&& o_seg_value === expected_glyph(model_nibble())
			&& o_led_sel_high === model_sel && o_led_edit === model_edit;
	endfunction

	task automatic step_cycle;
		@(posedge i_clk);
		#1;
	endtask

	task automatic set_button(input int btn, input logic value);
		case (btn)
			BTN_UP:     i_btn_up = value;
			BTN_DOWN:   i_btn_down = value;
			BTN_SELECT: i_btn_select = value;
			default:    i_btn_edit = value;
		endcase
	endtask

	task automatic apply_press(input int btn);
		logic [3:0] nib;
		nib = model_nibble();
		if (btn == BTN_SELECT) begin
			model_sel = ~model_sel;
		end else if (btn == BTN_EDIT) begin
			model_edit = ~model_edit;
		end else if (model_edit) begin
			nib = (btn == BTN_UP) ? nib + 4'd1 : nib - 4'd1;  // No carry into neighbors.
			model_limit[model_sel][model_idx[model_sel]*4 +: 4] = nib;
		end else if (btn == BTN_UP) begin
			model_idx[model_sel] = model_idx[model_sel] + 2'd1;
		end else begin
			model_idx[model_sel] = model_idx[model_sel] - 2'd1;
		end
	endtask

	task automatic check_display(input string what);
		assert (o_seg_index === expected_glyph({2'b00, model_idx[model_sel]})) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, index digit %h", $time, what, o_seg_index);
		end
		assert (o_seg_value === expected_glyph(model_nibble())) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, value digit %h", $time, what, o_seg_value);
		end
		assert (o_led_sel_high === model_sel && o_led_edit === model_edit) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, LEDs %b%b", $time, what, o_led_sel_high, o_led_edit);
		end
	endtask

	// Holds, releases, then waits for the displays to follow.
	task automatic press_button(input int btn);
		int waited;
		set_button(btn, 1'b1);
		repeat (12) step_cycle();
		set_button(btn, 1'b0);
		repeat (12) step_cycle();
		apply_press(btn);
		waited = 0;
		while (!display_matches() && waited < 20) begin
			step_cycle();
			waited++;
		end
		check_display($sformatf("after %s press", button_name(btn)));
	endtask

	task automatic random_run;
		int btn;
		int count;
		btn = $random(seed) & 1;
		count = 1 + ($random(seed) & 3);
		repeat (count) press_button(btn);
	endtask

	task automatic phase_length(input logic level, output int length);
		length = 0;
		while (o_pulse !== level && length < 3000) begin
			step_cycle();
			length++;
		end
		if (o_pulse !== level) begin
			failure_count++;
			$display("Pulse phase never ended, output stuck at %b at %0t", o_pulse, $time);
		end
	endtask

	// The first two boundaries only synchronize to the waveform.
	task automatic check_pulse_shape(input string what);
		int length;
		phase_length(1'b1, length);
		phase_length(1'b0, length);
		phase_length(1'b1, length);
		assert (length == int'(model_limit[0]) + 1) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s low phase of %0d cycles", $time, what, length);
		end
		phase_length(1'b0, length);
		assert (length == int'(model_limit[1]) + 1) else begin
			mismatch_count++;
			$display("Mismatch at %0t: %s high phase of %0d cycles", $time, what, length);
		end
	endtask

	task automatic load_limit(input bit target, input logic [15:0] value);
		logic [3:0] diff;
		if (model_sel != target) press_button(BTN_SELECT);
		for (int i = 0; i < pulse_cfg_pkg::CFG_NIBBLES; i++) begin
			if (model_edit) press_button(BTN_EDIT);
			while (model_idx[target] != 2'(i)) press_button(BTN_UP);
			press_button(BTN_EDIT);
			diff = value[i*4 +: 4] - model_nibble();
			if (diff <= 4'd8) begin
				repeat (diff) press_button(BTN_UP);
			end else begin
				repeat (16 - diff) press_button(BTN_DOWN);
			end
		end
	endtask

	task automatic bounce_button(input int btn);
		bounce_active = 1'b1;
		set_button(btn, 1'b1);
		repeat (2) step_cycle();
		set_button(btn, 1'b0);
		repeat (16) step_cycle();
		check_display($sformatf("bounce on %s", button_name(btn)));
		bounce_active = 1'b0;
	endtask

	initial begin
		seed = 55609;
		mismatch_count = 0;
		failure_count = 0;
		bounce_active = 1'b0;
		i_arst_n = 1'b0;
		i_btn_up = 1'b0;
		i_btn_down = 1'b0;
		i_btn_select = 1'b0;
		i_btn_edit = 1'b0;
		model_limit[0] = pulse_cfg_pkg::CFG_LOW_RESET;
		model_limit[1] = pulse_cfg_pkg::CFG_HIGH_RESET;
		model_idx[0] = 2'd0;
		model_idx[1] = 2'd0;
		model_sel = 1'b0;
		model_edit = 1'b0;
		repeat (5) @(posedge i_clk);
		#1 i_arst_n = 1'b1;
		step_cycle();  // Decoders load the first nibble.
		check_display("reset");
		assert (o_pulse === 1'b0) else begin
			mismatch_count++;
			$display("Mismatch at %0t: o_pulse high after reset", $time);
		end
		check_pulse_shape("reset");
		repeat (4) random_run();
		press_button(BTN_SELECT);
		repeat (3) random_run();
		press_button(BTN_EDIT);
		repeat (3) random_run();
		press_button(BTN_SELECT);
		repeat (3) random_run();
		load_limit(1'b0, 16'h0003);
		load_limit(1'b1, 16'h0005);
		check_pulse_shape("edited");
		for (int b = 0; b < 4; b++) bounce_button(b);
		$display("Checks done with %0d mismatches and %0d other failures",
			mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== pulse_tuner.f ====
verilog/pulse_cfg_pkg.sv
verilog/board_io_pkg.sv
verilog/button_debouncer.sv
verilog/limit_editor.sv
verilog/pulse_generator.sv
verilog/hex_to_segments.sv
verilog/pulse_tuner_top.sv
verif/pulse_tuner_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
TOP        := pulse_tuner_tb
RTL_TOP    := pulse_tuner_top
FILELIST   := pulse_tuner.f
BUILD_DIR  := obj_dir
BINARY     := $(BUILD_DIR)/V$(TOP)
PASS_MSG   := All tests passed!

.PHONY: all run lint clean

all: run

$(BINARY): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter verilog/%,$(shell cat $(FILELIST)))

clean:
	rm -rf $(BUILD_DIR)
